//--- verilog/gpio_pkg.sv
/* Shared GPIO definitions: APB sizes, register map, function selects and UART states.
   Referenced by scoped name from the RTL and the testbench. */
package gpio_pkg;

	// APB bus sizes
	localparam int APB_AW = 16;
	localparam int APB_DW = 32;

	typedef logic [APB_AW-1:0] apb_aw_t;
	typedef logic [APB_DW-1:0] apb_dw_t;

	// Baud divisor width
	localparam int DIV_W = 16;

	// Register word offsets, anything else is unmapped
	typedef enum logic [15:0] {
		REG_OUT       = 16'h0000,
		REG_DIR       = 16'h0004,
		REG_IN        = 16'h0008,
		REG_FSEL      = 16'h000c,
		REG_UART_DIV  = 16'h0010,
		REG_UART_DATA = 16'h0014,
		REG_UART_STAT = 16'h0018
	} reg_addr_e;

	// Per-pad function select
	typedef enum logic {
		FSEL_GPIO = 1'b0,
		FSEL_UART = 1'b1
	} fsel_e;

	// UART transmitter states
	typedef enum logic [1:0] {
		UART_IDLE  = 2'd0,
		UART_START = 2'd1,
		UART_DATA  = 2'd2,
		UART_STOP  = 2'd3
	} uart_state_e;

endpackage

//--- verilog/uart_ctrl_if.sv
/* Transmit control between the register file and the UART transmitter.
   The register side launches frames, the transmitter reports busy. */
interface uart_ctrl_if;

	logic [7:0]                  tx_data;
	logic                        tx_start;
	logic [gpio_pkg::DIV_W-1:0]  divisor;
	logic                        busy;

	// Register file side
	modport regs_mp (
		output tx_data,
		output tx_start,
		output divisor,
		input  busy
	);

	// Transmitter side, divisor goes to the baud timer separately
	modport uart_mp (
		input  tx_data,
		input  tx_start,
		output busy
	);

endinterface

//--- verilog/baud_timer.sv
/* Bit period timer. While running it ticks once every divisor+1 cycles,
   first tick divisor+1 cycles after run rises. */
module baud_timer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        run_i,
	input  logic [gpio_pkg::DIV_W-1:0]  divisor_i,
	output logic                        tick_o
);

	logic [gpio_pkg::DIV_W-1:0] count_q;
	logic                       wrap;

	// >= keeps the counter sane if the divisor drops mid-frame
	assign wrap = (count_q >= divisor_i);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (!run_i || wrap) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	assign tick_o = run_i && wrap;

endmodule

//--- verilog/uart_tx_fsm.sv
/* UART transmit state machine, 8N1, LSB first. Starts on a strobe in idle
   and advances one bit per baud tick; strobes while busy are dropped. */
module uart_tx_fsm (
	input  logic            clk,
	input  logic            rst_n,

	uart_ctrl_if.uart_mp    uart,

	input  logic            bit_tick_i,
	output logic            timer_run_o,
	output logic            uart_tx_o
);

	gpio_pkg::uart_state_e  state_q;
	logic [7:0]             shift_q;
	logic [2:0]             bit_cnt_q;
	logic                   line_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= gpio_pkg::UART_IDLE;
			bit_cnt_q <= '0;
			line_q    <= 1'b1;
		end else begin
			case (state_q)
				gpio_pkg::UART_IDLE: begin
					if (uart.tx_start) begin
						state_q <= gpio_pkg::UART_START;
						line_q  <= 1'b0;
					end
				end
				gpio_pkg::UART_START: begin
					if (bit_tick_i) begin
						state_q   <= gpio_pkg::UART_DATA;
						bit_cnt_q <= '0;
						line_q    <= shift_q[0];
					end
				end
				gpio_pkg::UART_DATA: begin
					if (bit_tick_i) begin
						if (bit_cnt_q == 3'd7) begin
							state_q <= gpio_pkg::UART_STOP;
							line_q  <= 1'b1;
						end else begin
							bit_cnt_q <= bit_cnt_q + 3'd1;
							line_q    <= shift_q[0];
						end
					end
				end
				gpio_pkg::UART_STOP: begin
					if (bit_tick_i) begin
						state_q <= gpio_pkg::UART_IDLE;
					end
				end
				default: state_q <= gpio_pkg::UART_IDLE;
			endcase
		end
	end

	// Byte loads on the accepted strobe, shifts as each data bit goes out
	always_ff @(posedge clk) begin
		if (state_q == gpio_pkg::UART_IDLE && uart.tx_start) begin
			shift_q <= uart.tx_data;
		end else if (bit_tick_i && state_q != gpio_pkg::UART_IDLE &&
				state_q != gpio_pkg::UART_STOP) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	assign uart.busy   = (state_q != gpio_pkg::UART_IDLE);
	assign timer_run_o = (state_q != gpio_pkg::UART_IDLE);
	assign uart_tx_o   = line_q;

endmodule

//--- verilog/gpio_pad_mux.sv
/* Pad function mux with tristate drivers and a registered input path.
   Only UART_PAD has a UART source; elsewhere the select falls back to software. */
module gpio_pad_mux #(
	parameter int N_PADS   = 16,
	parameter int UART_PAD = 15
) (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic [N_PADS-1:0]              sw_out_i,
	input  logic [N_PADS-1:0]              sw_oe_i,
	input  gpio_pkg::fsel_e [N_PADS-1:0]   fsel_i,
	input  logic                           uart_tx_i,

	output logic [N_PADS-1:0]              pad_in_q_o,

	inout  wire  [N_PADS-1:0]              pads
);

	logic [N_PADS-1:0] drive_out;
	logic [N_PADS-1:0] drive_oe;

	for (genvar g = 0; g < N_PADS; g++) begin : gen_pad
		if (g == UART_PAD) begin : gen_uart
			// UART owns the pad outright, enable forced on
			assign drive_out[g] = (fsel_i[g] == gpio_pkg::FSEL_UART) ? uart_tx_i : sw_out_i[g];
			assign drive_oe[g]  = (fsel_i[g] == gpio_pkg::FSEL_UART) ? 1'b1 : sw_oe_i[g];
		end else begin : gen_sw
			assign drive_out[g] = sw_out_i[g];
			assign drive_oe[g]  = sw_oe_i[g];
		end

		assign pads[g] = drive_oe[g] ? drive_out[g] : 1'bz;
	end

	// One register stage before software sees the pads
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pad_in_q_o <= '0;
		end else begin
			pad_in_q_o <= pads;
		end
	end

endmodule

//--- verilog/gpio_regs.sv
/* APB register file for pad output, direction, function select, input readback
   and UART control. No wait states; unmapped offsets return an error. */
module gpio_regs #(
	parameter int N_PADS = 16
) (
	input  logic                              clk,
	input  logic                              rst_n,

	// APB slave
	input  logic                              psel_i,
	input  logic                              penable_i,
	input  logic                              pwrite_i,
	input  gpio_pkg::apb_aw_t                 paddr_i,
	input  gpio_pkg::apb_dw_t                 pwdata_i,
	output gpio_pkg::apb_dw_t                 prdata_o,
	output logic                              pready_o,
	output logic                              pslverr_o,

	// Pad control
	output logic [N_PADS-1:0]                 sw_out_o,
	output logic [N_PADS-1:0]                 sw_oe_o,
	output gpio_pkg::fsel_e [N_PADS-1:0]      fsel_o,
	input  logic [N_PADS-1:0]                 pad_in_i,

	uart_ctrl_if.regs_mp                      uart
);

	gpio_pkg::reg_addr_e              addr;
	logic                             access;
	logic                             wr_en;
	logic                             mapped;
	gpio_pkg::apb_dw_t                rdata;

	logic [N_PADS-1:0]                out_q;
	logic [N_PADS-1:0]                dir_q;
	gpio_pkg::fsel_e [N_PADS-1:0]     fsel_q;
	logic [gpio_pkg::DIV_W-1:0]       div_q;
	logic [7:0]                       data_q;
	logic                             tx_start_q;

	assign addr   = gpio_pkg::reg_addr_e'(paddr_i);
	assign access = psel_i && penable_i;
	assign wr_en  = access && pwrite_i && mapped;

	// Address decode and read mux
	always_comb begin
		mapped = 1'b1;
		rdata  = '0;
		case (addr)
			gpio_pkg::REG_OUT:       rdata[N_PADS-1:0] = out_q;
			gpio_pkg::REG_DIR:       rdata[N_PADS-1:0] = dir_q;
			gpio_pkg::REG_IN:        rdata[N_PADS-1:0] = pad_in_i;
			gpio_pkg::REG_FSEL:      rdata[N_PADS-1:0] = fsel_q;
			gpio_pkg::REG_UART_DIV:  rdata[gpio_pkg::DIV_W-1:0] = div_q;
			gpio_pkg::REG_UART_DATA: rdata[7:0] = data_q;
			gpio_pkg::REG_UART_STAT: rdata[0] = uart.busy;
			default:                 mapped = 1'b0;
		endcase
	end

	assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
	assign pready_o  = 1'b1;
	assign pslverr_o = access && !mapped;

	// Control registers, written at the edge ending the access cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_q      <= '0;
			dir_q      <= '0;
			div_q      <= '0;
			tx_start_q <= 1'b0;
			for (int i = 0; i < N_PADS; i++) begin
				fsel_q[i] <= gpio_pkg::FSEL_GPIO;
			end
		end else begin
			// Strobe lasts a single cycle
			tx_start_q <= 1'b0;
			if (wr_en) begin
				case (addr)
					gpio_pkg::REG_OUT:       out_q <= pwdata_i[N_PADS-1:0];
					gpio_pkg::REG_DIR:       dir_q <= pwdata_i[N_PADS-1:0];
					gpio_pkg::REG_FSEL: begin
						for (int i = 0; i < N_PADS; i++) begin
							fsel_q[i] <= gpio_pkg::fsel_e'(pwdata_i[i]);
						end
					end
					gpio_pkg::REG_UART_DIV:  div_q <= pwdata_i[gpio_pkg::DIV_W-1:0];
					gpio_pkg::REG_UART_DATA: tx_start_q <= 1'b1;
					// IN and UART_STAT are read only
					default: ;
				endcase
			end
		end
	end

	// Transmit byte, captured alongside the strobe
	always_ff @(posedge clk) begin
		if (wr_en && addr == gpio_pkg::REG_UART_DATA) begin
			data_q <= pwdata_i[7:0];
		end
	end

	assign sw_out_o = out_q;
	assign sw_oe_o  = dir_q;
	assign fsel_o   = fsel_q;

	assign uart.tx_data  = data_q;
	assign uart.tx_start = tx_start_q;
	assign uart.divisor  = div_q;

endmodule

//--- verilog/gpio_top.sv
/* GPIO subsystem top: APB register file, pad mux and UART transmitter.
   Plain APB and pad ports to the rest of the SoC. */
module gpio_top #(
	parameter int N_PADS   = 16,
	parameter int UART_PAD = 15
) (
	input  logic                clk,
	input  logic                rst_n,

	// APB slave
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  gpio_pkg::apb_aw_t   paddr_i,
	input  gpio_pkg::apb_dw_t   pwdata_i,
	output gpio_pkg::apb_dw_t   prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,

	inout  wire [N_PADS-1:0]    pads
);

	logic [N_PADS-1:0]             sw_out;
	logic [N_PADS-1:0]             sw_oe;
	gpio_pkg::fsel_e [N_PADS-1:0]  fsel;
	logic [N_PADS-1:0]             pad_in_q;
	logic                          timer_run;
	logic                          bit_tick;
	logic                          uart_tx;

	uart_ctrl_if i_uart_if ();

	gpio_regs #(
		.N_PADS    (N_PADS)
	) i_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.sw_out_o  (sw_out),
		.sw_oe_o   (sw_oe),
		.fsel_o    (fsel),
		.pad_in_i  (pad_in_q),
		.uart      (i_uart_if.regs_mp)
	);

	gpio_pad_mux #(
		.N_PADS     (N_PADS),
		.UART_PAD   (UART_PAD)
	) i_pad_mux (
		.clk        (clk),
		.rst_n      (rst_n),
		.sw_out_i   (sw_out),
		.sw_oe_i    (sw_oe),
		.fsel_i     (fsel),
		.uart_tx_i  (uart_tx),
		.pad_in_q_o (pad_in_q),
		.pads       (pads)
	);

	uart_tx_fsm i_uart_tx (
		.clk         (clk),
		.rst_n       (rst_n),
		.uart        (i_uart_if.uart_mp),
		.bit_tick_i  (bit_tick),
		.timer_run_o (timer_run),
		.uart_tx_o   (uart_tx)
	);

	baud_timer i_baud (
		.clk       (clk),
		.rst_n     (rst_n),
		.run_i     (timer_run),
		.divisor_i (i_uart_if.divisor),
		.tick_o    (bit_tick)
	);

endmodule

//--- verification/gpio_properties.sv
/* Transmitter assertions, bound into every uart_tx_fsm instance. */
module gpio_properties (
	input logic                  clk,
	input logic                  rst_n,
	input gpio_pkg::uart_state_e state_i,
	input logic                  tx_start_i,
	input logic                  uart_tx_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Line rests high between frames
	idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
		state_i == gpio_pkg::UART_IDLE |-> uart_tx_i)
		else $error("UART line low while idle");

	// An accepted strobe opens the start bit
	strobe_to_start: assert property (@(posedge clk) disable iff (!rst_n)
		(state_i == gpio_pkg::UART_IDLE && tx_start_i) |=> state_i == gpio_pkg::UART_START)
		else $error("strobe in idle did not enter the start state");

	start_bit_low: assert property (@(posedge clk) disable iff (!rst_n)
		state_i == gpio_pkg::UART_START |-> !uart_tx_i)
		else $error("UART line not low during the start bit");

endmodule

bind uart_tx_fsm gpio_properties i_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.state_i    (state_q),
	.tx_start_i (uart.tx_start),
	.uart_tx_i  (uart_tx_o)
);

//--- verification/gpio_tb.sv
/* Directed testbench for gpio_top: registers, pads, input capture and UART frames.
   Inputs change on the falling clock edge, the run stops at the first mismatch. */
module gpio_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_PADS   = 16;
	localparam int UART_PAD = 15;
	localparam int UART_DIV = 3;
	// Two 10-bit frames at DIV 3 are about 100 cycles, register traffic adds a few hundred
	localparam int MAX_CYCLES = 3000;

	logic              clk;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	gpio_pkg::apb_aw_t paddr;
	gpio_pkg::apb_dw_t pwdata;
	gpio_pkg::apb_dw_t prdata;
	logic              pready;
	logic              pslverr;
	wire  [N_PADS-1:0] pads;
	logic [N_PADS-1:0] tb_drv;
	logic [N_PADS-1:0] tb_en;
	logic [N_PADS-1:0] exp_out;
	logic [N_PADS-1:0] exp_dir;
	integer            seed;
	int                cycles = 0;

	gpio_top #(.N_PADS(N_PADS), .UART_PAD(UART_PAD)) i_dut (
		.clk(clk), .rst_n(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.pslverr_o(pslverr), .pads(pads)
	);

	// External drivers on the pads
	for (genvar g = 0; g < N_PADS; g++) begin : gen_tb_pad
		assign pads[g] = tb_en[g] ? tb_drv[g] : 1'bz;
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
			$display("test failed");
			$fatal(1, "run aborted");
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic apb_xfer(input logic wr, input gpio_pkg::apb_aw_t addr,
			input gpio_pkg::apb_dw_t wdata, output gpio_pkg::apb_dw_t rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input gpio_pkg::apb_aw_t addr, input gpio_pkg::apb_dw_t data,
			output logic err);
		gpio_pkg::apb_dw_t unused;
		apb_xfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input gpio_pkg::apb_aw_t addr, output gpio_pkg::apb_dw_t data,
			output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic write_reg(input gpio_pkg::apb_aw_t addr, input gpio_pkg::apb_dw_t data);
		logic err;
		apb_write(addr, data, err);
		check(err, 0, "pslverr on a mapped write");
	endtask

	task automatic read_expect(input gpio_pkg::apb_aw_t addr, input logic [31:0] exp,
			input string what);
		gpio_pkg::apb_dw_t data;
		logic              err;
		apb_read(addr, data, err);
		check(err, 0, {what, " pslverr"});
		check(data, exp, what);
	endtask

	// Start bit, eight data bits LSB first, stop bit
	function automatic logic frame_bit(input logic [7:0] data, input int k);
		if (k == 0)
			return 1'b0;
		else if (k == 9)
			return 1'b1;
		return data[k-1];
	endfunction

	task automatic send_frame(input logic [7:0] data, input bit overlap);
		write_reg(gpio_pkg::REG_UART_DATA, data);
		// Mid start bit sits three falling edges after the strobe edge
		if (overlap) begin
			// The dropped second write spans exactly those three edges
			write_reg(gpio_pkg::REG_UART_DATA, ~data);
		end else begin
			repeat (3) @(negedge clk);
		end
		for (int k = 0; k < 10; k++) begin
			check(pads[UART_PAD], frame_bit(data, k), $sformatf("UART bit %0d", k));
			if (k == 4) begin
				// The status read takes three of the four edges of a bit
				read_expect(gpio_pkg::REG_UART_STAT, 1, "UART_STAT during frame");
				repeat (1) @(negedge clk);
			end else if (k < 9) begin
				repeat (4) @(negedge clk);
			end
		end
		// Busy drops at the tick ending the stop bit, before this read samples
		read_expect(gpio_pkg::REG_UART_STAT, 0, "UART_STAT after frame");
		check(pads[UART_PAD], 1, "UART line idle after frame");
	endtask

	task automatic test_reset;
		check(pready, 1, "pready");
		check(pads, {N_PADS{1'bz}}, "pads released after reset");
		read_expect(gpio_pkg::REG_OUT, 0, "OUT after reset");
		read_expect(gpio_pkg::REG_DIR, 0, "DIR after reset");
		read_expect(gpio_pkg::REG_FSEL, 0, "FSEL after reset");
		read_expect(gpio_pkg::REG_UART_DIV, 0, "DIV after reset");
		read_expect(gpio_pkg::REG_UART_STAT, 0, "UART_STAT after reset");
	endtask

	task automatic test_sw_output;
		exp_dir = '1;
		exp_out = $random(seed);
		write_reg(gpio_pkg::REG_DIR, exp_dir);
		write_reg(gpio_pkg::REG_OUT, exp_out);
		check(pads, exp_out, "pads follow OUT");
		read_expect(gpio_pkg::REG_OUT, exp_out, "OUT readback");
		read_expect(gpio_pkg::REG_DIR, exp_dir, "DIR readback");
	endtask

	task automatic test_input_readback;
		exp_dir = $random(seed);
		exp_out = $random(seed);
		write_reg(gpio_pkg::REG_DIR, exp_dir);
		write_reg(gpio_pkg::REG_OUT, exp_out);
		tb_drv = $random(seed);
		tb_en  = ~exp_dir;
		read_expect(gpio_pkg::REG_IN, (exp_out & exp_dir) | (tb_drv & ~exp_dir), "IN readback");
		tb_en = '0;
	endtask

	task automatic test_unmapped;
		gpio_pkg::apb_dw_t data;
		logic              err;
		apb_read(16'h001c, data, err);
		check({err, data}, {1'b1, 32'h0}, "read of 0x1C");
		apb_read(16'h0040, data, err);
		check({err, data}, {1'b1, 32'h0}, "read of 0x40");
		apb_write(16'h001c, 32'hffff_ffff, err);
		check(err, 1, "write of 0x1C");
		apb_write(16'h0040, 32'hffff_ffff, err);
		check(err, 1, "write of 0x40");
		read_expect(gpio_pkg::REG_OUT, exp_out, "OUT after unmapped writes");
		read_expect(gpio_pkg::REG_DIR, exp_dir, "DIR after unmapped writes");
		read_expect(gpio_pkg::REG_FSEL, 0, "FSEL after unmapped writes");
		read_expect(gpio_pkg::REG_UART_DIV, 0, "DIV after unmapped writes");
	endtask

	task automatic test_uart_frame;
		write_reg(gpio_pkg::REG_FSEL, 1 << UART_PAD);
		write_reg(gpio_pkg::REG_UART_DIV, UART_DIV);
		read_expect(gpio_pkg::REG_FSEL, 1 << UART_PAD, "FSEL readback");
		check(pads[UART_PAD], 1, "UART line idle before frame");
		send_frame(8'ha5, 1'b0);
	endtask

	task automatic test_busy_drop;
		send_frame(8'h3c, 1'b1);
		exp_dir = '1;
		exp_out[UART_PAD] = 1'b0;
		write_reg(gpio_pkg::REG_DIR, exp_dir);
		write_reg(gpio_pkg::REG_OUT, exp_out);
		check(pads[UART_PAD], 1, "UART pad ignores OUT while selected");
		write_reg(gpio_pkg::REG_FSEL, 0);
		check(pads, exp_out, "pads follow OUT after FSEL cleared");
		exp_out[UART_PAD] = 1'b1;
		write_reg(gpio_pkg::REG_OUT, exp_out);
		check(pads, exp_out, "UART pad back under software");
	endtask

	initial begin
		seed    = 12378;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		tb_drv  = '0;
		tb_en   = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset;
		test_sw_output;
		test_input_readback;
		test_unmapped;
		test_uart_frame;
		test_busy_drop;
		$display("test passed");
		$finish;
	end

endmodule

//--- verilog.f
verilog/gpio_pkg.sv
verilog/uart_ctrl_if.sv
verilog/baud_timer.sv
verilog/uart_tx_fsm.sv
verilog/gpio_pad_mux.sv
verilog/gpio_regs.sv
verilog/gpio_top.sv
verification/gpio_properties.sv
verification/gpio_tb.sv
